// ==== dsc_conv.f ====
hw/dsc_pkg.sv
hw/dsc_ctrl.sv
hw/dsc_dw_unit.sv
hw/dsc_pw_unit.sv
hw/dsc_top.sv
test/tb_dsc.sv

// ==== hw/dsc_ctrl.sv ====
/*
	Depthwise-separable convolution controller
	Sequences kernel, window and pointwise loads, the two compute steps
	and the result writes, and generates all memory addresses
*/
module dsc_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic S,
	input  logic first_par,
	input  logic [dsc_pkg::NOF_W-1:0] nof,
	input  logic [dsc_pkg::TILE_W-1:0] tox_n,
	input  logic [dsc_pkg::TILE_W-1:0] toy_n,
	output logic dw_load,
	output logic win_load,
	output logic pw_load,
	output logic dw_calc,
	output logic pw_calc,
	output logic pw_first,
	output logic write,
	output logic finish,
	output logic [dsc_pkg::FMINT_AW-1:0] fmint_addr,
	output logic [dsc_pkg::FMO_AW-1:0] fmo_addr,
	output logic [dsc_pkg::KDW_AW-1:0] kdw_addr,
	output logic [dsc_pkg::KPW_AW-1:0] kpw_addr
);
	import dsc_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		LOAD_K_DW,
		LOAD_WIN,
		DW_CONV,
		LOAD_K_PW,
		PW_CONV,
		WRITE,
		FINISHED
	} state_t;

	state_t state;

	// Cycle counter shared by the three load phases
	logic [KDW_AW-1:0] cnt;

	// Window position inside the 3x3x2 input patch
	logic [$clog2(KX)-1:0] kx;
	logic [$clog2(KY)-1:0] ky;
	logic [FMINT_AW-1:0] plane_base;
	logic [FMINT_AW-1:0] row_base;

	// Window origin of the current pixel and of the current tile row
	logic [FMINT_AW-1:0] win_org;
	logic [FMINT_AW-1:0] row_org;
	logic [FMINT_AW-1:0] col_step;
	logic [FMINT_AW-1:0] row_step;

	// Output tile position and output channel
	logic [TILE_W-1:0] tx;
	logic [TILE_W-1:0] ty;
	logic [NOF_W-1:0] of;
	logic [FMO_AW-1:0] fmo_plane;
	logic [FMO_AW-1:0] fmo_row;

	assign col_step   = FMINT_AW'(1) << S;
	assign row_step   = FMINT_AW'(TIX) << S;
	assign fmint_addr = win_org + plane_base + row_base + FMINT_AW'(kx);
	assign fmo_addr   = fmo_plane + fmo_row + FMO_AW'(tx);

	assign dw_calc = state == DW_CONV;
	assign pw_calc = state == PW_CONV;
	assign write   = state == WRITE;
	assign finish  = state == FINISHED;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state      <= IDLE;
			cnt        <= '0;
			kx         <= '0;
			ky         <= '0;
			plane_base <= '0;
			row_base   <= '0;
			win_org    <= '0;
			row_org    <= '0;
			tx         <= '0;
			ty         <= '0;
			of         <= '0;
			fmo_plane  <= '0;
			fmo_row    <= '0;
			kdw_addr   <= '0;
			kpw_addr   <= '0;
			pw_first   <= 1'b0;
			dw_load    <= 1'b0;
			win_load   <= 1'b0;
			pw_load    <= 1'b0;
		end else begin
			// Strobes follow their address by one cycle, matching the read latency
			dw_load  <= (state == LOAD_K_DW) && (cnt < WIN_N);
			win_load <= (state == LOAD_WIN) && (cnt < WIN_N);
			pw_load  <= (state == LOAD_K_PW) && (cnt < NNP);

			case (state)
			IDLE: begin
				if (start) begin
					state      <= LOAD_K_DW;
					pw_first   <= first_par;
					cnt        <= '0;
					kx         <= '0;
					ky         <= '0;
					plane_base <= '0;
					row_base   <= '0;
					win_org    <= '0;
					row_org    <= '0;
					tx         <= '0;
					ty         <= '0;
					of         <= '0;
					fmo_plane  <= '0;
					fmo_row    <= '0;
					kdw_addr   <= '0;
					kpw_addr   <= '0;
				end
			end
			LOAD_K_DW: begin
				if (cnt == WIN_N) begin
					state <= LOAD_WIN;
					cnt   <= '0;
				end else begin
					cnt <= cnt + 1'b1;
					if (cnt < WIN_N - 1)
						kdw_addr <= kdw_addr + 1'b1;
				end
			end
			LOAD_WIN: begin
				if (cnt == WIN_N) begin
					state <= DW_CONV;
					cnt   <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
				// Column, then row, then channel plane
				if (cnt == WIN_N - 1) begin
					kx         <= '0;
					ky         <= '0;
					row_base   <= '0;
					plane_base <= '0;
				end else if (cnt < WIN_N - 1) begin
					if (kx != KX - 1) begin
						kx <= kx + 1'b1;
					end else begin
						kx <= '0;
						if (ky != KY - 1) begin
							ky       <= ky + 1'b1;
							row_base <= row_base + FMINT_AW'(TIX);
						end else begin
							ky         <= '0;
							row_base   <= '0;
							plane_base <= plane_base + FMINT_AW'(FMINT_PLANE);
						end
					end
				end
			end
			DW_CONV: begin
				state <= LOAD_K_PW;
				cnt   <= '0;
			end
			LOAD_K_PW: begin
				if (cnt == NNP) begin
					state <= PW_CONV;
					cnt   <= '0;
				end else begin
					cnt <= cnt + 1'b1;
					if (cnt < NNP - 1)
						kpw_addr <= kpw_addr + 1'b1;
				end
			end
			PW_CONV: state <= WRITE;
			WRITE: begin
				cnt <= '0;
				if (of != nof - NOF_W'(1)) begin
					// Next output channel of the same pixel
					state     <= LOAD_K_PW;
					of        <= of + 1'b1;
					fmo_plane <= fmo_plane + FMO_AW'(FMO_PLANE);
					kpw_addr  <= kpw_addr + 1'b1;
				end else begin
					of        <= '0;
					fmo_plane <= '0;
					kpw_addr  <= '0;
					if (tx != tox_n - TILE_W'(1)) begin
						state   <= LOAD_WIN;
						tx      <= tx + 1'b1;
						win_org <= win_org + col_step;
					end else if (ty != toy_n - TILE_W'(1)) begin
						state   <= LOAD_WIN;
						tx      <= '0;
						ty      <= ty + 1'b1;
						fmo_row <= fmo_row + FMO_AW'(tox_n);
						row_org <= row_org + row_step;
						win_org <= row_org + row_step;
					end else begin
						state <= FINISHED;
					end
				end
			end
			FINISHED: state <= IDLE;
			default:  state <= IDLE;
			endcase
		end
	end

endmodule

// ==== hw/dsc_dw_unit.sv ====
/*
	Depthwise datapath
	Window and kernel shift registers, per-channel 3x3 multiply-accumulate
	and ReLU6 on the registered results
*/
module dsc_dw_unit (
	input  logic clk,
	input  logic rst,
	input  logic dw_load,
	input  logic win_load,
	input  logic dw_calc,
	input  logic signed [dsc_pkg::WG_W-1:0] kdw_data,
	input  logic signed [dsc_pkg::PX_W-1:0] fmint_data,
	output logic [dsc_pkg::NPAR*dsc_pkg::PX_W-1:0] relu_vec
);
	import dsc_pkg::*;

	// Channel-major, then row, then column
	logic signed [PX_W-1:0] win [0:WIN_N-1];
	logic signed [WG_W-1:0] wgt [0:WIN_N-1];

	logic signed [PX_W-1:0] dw_sum [0:NPAR-1];
	logic signed [PX_W-1:0] dw_res [0:NPAR-1];

	// New words enter at the last slot
	always_ff @(posedge clk) begin
		if (dw_load) begin
			for (int i = 0; i < WIN_N - 1; i++)
				wgt[i] <= wgt[i+1];
			wgt[WIN_N-1] <= kdw_data;
		end
		if (win_load) begin
			for (int i = 0; i < WIN_N - 1; i++)
				win[i] <= win[i+1];
			win[WIN_N-1] <= fmint_data;
		end
	end

	always_comb begin
		for (int c = 0; c < NPAR; c++) begin
			dw_sum[c] = '0;
			for (int k = 0; k < KX * KY; k++)
				dw_sum[c] = dw_sum[c] + fx_term(win[c*KX*KY + k], wgt[c*KX*KY + k]);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int c = 0; c < NPAR; c++)
				dw_res[c] <= '0;
		end else if (dw_calc) begin
			for (int c = 0; c < NPAR; c++)
				dw_res[c] <= dw_sum[c];
		end
	end

	// ReLU6 clamp to [0, 6.0]
	always_comb begin
		for (int c = 0; c < NPAR; c++) begin
			if (dw_res[c][PX_W-1])
				relu_vec[c*PX_W +: PX_W] = '0;
			else if (dw_res[c] >= RELU_MAX)
				relu_vec[c*PX_W +: PX_W] = PX_W'(RELU_MAX);
			else
				relu_vec[c*PX_W +: PX_W] = dw_res[c];
		end
	end

endmodule

// ==== hw/dsc_pkg.sv ====
/*
	Depthwise-separable convolution engine, shared definitions
	Data format, kernel and tile sizes, memory depths and address widths
*/
package dsc_pkg;

	// Fixed-point format, Q3.12 pixels and Q0.7 weights
	localparam int PX_W     = 16;
	localparam int PX_FRAC  = 12;
	localparam int WG_W     = 8;
	localparam int WG_FRAC  = 7;
	localparam int RELU_MAX = 6 << PX_FRAC;

	// Kernel and pointwise sizes
	localparam int KX    = 3;
	localparam int KY    = 3;
	localparam int NPAR  = 2;
	localparam int NNP   = 2;
	localparam int POS_W = $clog2(NPAR + 1);
	localparam int WIN_N = KX * KY * NPAR;

	// Tile geometry
	localparam int TOX_MAX     = 4;
	localparam int TOY_MAX     = 4;
	localparam int MAX_NOF     = 4;
	localparam int TIX         = 9;
	localparam int TIY         = 9;
	localparam int FMINT_PLANE = TIX * TIY;
	localparam int FMO_PLANE   = TOX_MAX * TOY_MAX;

	// Memory depths
	localparam int FMINT_DEPTH = NPAR * FMINT_PLANE;
	localparam int FMO_DEPTH   = MAX_NOF * FMO_PLANE;
	localparam int KDW_DEPTH   = WIN_N;
	localparam int KPW_DEPTH   = NNP * MAX_NOF;

	// Address and field widths
	localparam int FMINT_AW = $clog2(FMINT_DEPTH);
	localparam int FMO_AW   = $clog2(FMO_DEPTH);
	localparam int KDW_AW   = $clog2(KDW_DEPTH);
	localparam int KPW_AW   = $clog2(KPW_DEPTH);
	localparam int NOF_W    = $clog2(MAX_NOF + 1);
	localparam int TILE_W   = $clog2(TOX_MAX + 1);

	// One multiply term, truncated by WG_FRAC with round half up, wrapped to PX_W
	function automatic logic signed [PX_W-1:0] fx_term(
		input logic signed [PX_W-1:0] px,
		input logic signed [WG_W-1:0] wg
	);
		logic signed [PX_W+WG_W-1:0] prod;
		prod = px * wg;
		return prod[WG_FRAC +: PX_W] + PX_W'(prod[WG_FRAC-1]);
	endfunction

endpackage

// ==== hw/dsc_pw_unit.sv ====
/*
	Pointwise datapath
	Tap weight and channel position shift registers and the output sum,
	started from zero or from the value already in the output buffer
*/
module dsc_pw_unit (
	input  logic clk,
	input  logic rst,
	input  logic pw_load,
	input  logic pw_calc,
	input  logic pw_first,
	input  logic signed [dsc_pkg::WG_W-1:0] kpw_data,
	input  logic [dsc_pkg::POS_W-1:0] kpw_pos,
	input  logic [dsc_pkg::NPAR*dsc_pkg::PX_W-1:0] relu_vec,
	input  logic signed [dsc_pkg::PX_W-1:0] fmo_data,
	output logic signed [dsc_pkg::PX_W-1:0] res
);
	import dsc_pkg::*;

	logic signed [WG_W-1:0] pw_wgt [0:NNP-1];
	logic [POS_W-1:0] pw_pos [0:NNP-1];
	logic signed [PX_W-1:0] tap_px [0:NNP-1];
	logic signed [PX_W-1:0] pw_sum;

	always_ff @(posedge clk) begin
		if (pw_load) begin
			for (int t = 0; t < NNP - 1; t++) begin
				pw_wgt[t] <= pw_wgt[t+1];
				pw_pos[t] <= pw_pos[t+1];
			end
			pw_wgt[NNP-1] <= kpw_data;
			pw_pos[NNP-1] <= kpw_pos;
		end
	end

	// Channel select per tap, positions past NPAR contribute nothing
	always_comb begin
		for (int t = 0; t < NNP; t++) begin
			tap_px[t] = '0;
			for (int c = 0; c < NPAR; c++)
				if (pw_pos[t] == c)
					tap_px[t] = relu_vec[c*PX_W +: PX_W];
		end
		pw_sum = pw_first ? '0 : fmo_data;
		for (int t = 0; t < NNP; t++)
			pw_sum = pw_sum + fx_term(tap_px[t], pw_wgt[t]);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			res <= '0;
		else if (pw_calc)
			res <= pw_sum;
	end

endmodule

// ==== hw/dsc_top.sv ====
/*
	Depthwise-separable convolution engine
	Controller plus depthwise and pointwise datapaths for one feature-map tile
*/
module dsc_top (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic S,
	input  logic first_par,
	input  logic [dsc_pkg::NOF_W-1:0] nof,
	input  logic [dsc_pkg::TILE_W-1:0] tox_n,
	input  logic [dsc_pkg::TILE_W-1:0] toy_n,
	input  logic signed [dsc_pkg::PX_W-1:0] fmint_data,
	input  logic signed [dsc_pkg::PX_W-1:0] fmo_data,
	input  logic signed [dsc_pkg::WG_W-1:0] kdw_data,
	input  logic signed [dsc_pkg::WG_W-1:0] kpw_data,
	input  logic [dsc_pkg::POS_W-1:0] kpw_pos,
	output logic [dsc_pkg::FMINT_AW-1:0] fmint_addr,
	output logic [dsc_pkg::FMO_AW-1:0] fmo_addr,
	output logic [dsc_pkg::KDW_AW-1:0] kdw_addr,
	output logic [dsc_pkg::KPW_AW-1:0] kpw_addr,
	output logic write,
	output logic finish,
	output logic signed [dsc_pkg::PX_W-1:0] res
);
	import dsc_pkg::*;

	logic dw_load;
	logic win_load;
	logic pw_load;
	logic dw_calc;
	logic pw_calc;
	logic pw_first;
	logic [NPAR*PX_W-1:0] relu_vec;

	dsc_ctrl i_ctrl (
		.clk(clk), .rst(rst), .start(start), .S(S), .first_par(first_par),
		.nof(nof), .tox_n(tox_n), .toy_n(toy_n),
		.dw_load(dw_load), .win_load(win_load), .pw_load(pw_load),
		.dw_calc(dw_calc), .pw_calc(pw_calc), .pw_first(pw_first),
		.write(write), .finish(finish),
		.fmint_addr(fmint_addr), .fmo_addr(fmo_addr),
		.kdw_addr(kdw_addr), .kpw_addr(kpw_addr)
	);

	dsc_dw_unit i_dw (
		.clk(clk), .rst(rst), .dw_load(dw_load), .win_load(win_load),
		.dw_calc(dw_calc), .kdw_data(kdw_data), .fmint_data(fmint_data),
		.relu_vec(relu_vec)
	);

	dsc_pw_unit i_pw (
		.clk(clk), .rst(rst), .pw_load(pw_load), .pw_calc(pw_calc),
		.pw_first(pw_first), .kpw_data(kpw_data), .kpw_pos(kpw_pos),
		.relu_vec(relu_vec), .fmo_data(fmo_data), .res(res)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the convolution engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dsc \
	-f dsc_conv.f -o sim_dsc

./obj_dir/sim_dsc | tee sim.log

grep -q "sim passed" sim.log
echo "Simulation passed"

// ==== test/dsc_golden.txt ====
# run <name> <S> <first_par> <nof> <tox_n> <toy_n>, then "<mem> <count>" and entries
# kdw/fmint: addr value; kpw: addr weight pos; exp: fmo_addr res in write order
run stride1_fresh 0 1 2 2 2
kdw 4
4 64
8 64
9 64
13 -64
kpw 4
0 64 0
1 32 1
2 64 1
3 -32 1
fmint 14
10 4096
20 8192
11 30000
21 30000
19 -8192
29 2048
30 0
81 12288
91 4096
82 2048
92 10240
90 20480
100 0
101 -4096
exp 8
0 4096
16 1024
1 12288
17 0
2 2560
18 2560
3 3072
19 1024
run stride2_accum 1 0 2 2 2
kdw 4
4 64
8 64
9 64
13 -64
kpw 4
0 64 0
1 32 1
2 64 1
3 -32 1
fmint 16
10 -4096
20 -4096
12 8192
22 8192
28 30000
38 30000
30 4096
40 4096
81 8192
91 0
83 16384
93 0
99 0
109 8192
101 4096
111 -4096
exp 8
0 5120
16 2048
1 18432
17 2048
2 14848
18 2560
3 6144
19 2048

// ==== test/tb_dsc.sv ====
/*
	Testbench for the depthwise-separable convolution engine
	Memory models, golden-file driven runs, write checks and timeout
*/
module tb_dsc;
	import dsc_pkg::*;

	logic clk;
	logic rst;
	logic start;
	logic S;
	logic first_par;
	logic [NOF_W-1:0] nof;
	logic [TILE_W-1:0] tox_n;
	logic [TILE_W-1:0] toy_n;
	logic signed [PX_W-1:0] fmint_data;
	logic signed [PX_W-1:0] fmo_data;
	logic signed [WG_W-1:0] kdw_data;
	logic signed [WG_W-1:0] kpw_data;
	logic [POS_W-1:0] kpw_pos;
	logic [FMINT_AW-1:0] fmint_addr;
	logic [FMO_AW-1:0] fmo_addr;
	logic [KDW_AW-1:0] kdw_addr;
	logic [KPW_AW-1:0] kpw_addr;
	logic write;
	logic finish;
	logic signed [PX_W-1:0] res;

	// Memory images
	logic signed [PX_W-1:0] fmint_mem [0:FMINT_DEPTH-1];
	logic signed [PX_W-1:0] fmo_mem [0:FMO_DEPTH-1];
	logic signed [WG_W-1:0] kdw_mem [0:KDW_DEPTH-1];
	logic signed [WG_W-1:0] kpw_mem [0:KPW_DEPTH-1];
	logic [POS_W-1:0] pos_mem [0:KPW_DEPTH-1];

	int exp_addr [$];
	int exp_val [$];
	string test_name;
	int errors;
	int checks;
	int cycles;
	int limit;
	int finish_cnt;
	bit running;
	bit run_done;

	dsc_top i_dut (
		.clk(clk), .rst(rst), .start(start), .S(S), .first_par(first_par),
		.nof(nof), .tox_n(tox_n), .toy_n(toy_n),
		.fmint_data(fmint_data), .fmo_data(fmo_data), .kdw_data(kdw_data),
		.kpw_data(kpw_data), .kpw_pos(kpw_pos),
		.fmint_addr(fmint_addr), .fmo_addr(fmo_addr), .kdw_addr(kdw_addr),
		.kpw_addr(kpw_addr), .write(write), .finish(finish), .res(res)
	);

	always #5 clk = ~clk;

	// One-cycle synchronous reads and output buffer updates on each write
	always @(posedge clk) begin
		fmint_data <= fmint_mem[fmint_addr];
		fmo_data   <= fmo_mem[fmo_addr];
		kdw_data   <= kdw_mem[kdw_addr];
		kpw_data   <= kpw_mem[kpw_addr];
		kpw_pos    <= pos_mem[kpw_addr];
		if (write)
			fmo_mem[fmo_addr] <= res;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Timeout after %0d cycles in run %s", cycles, test_name);
			$display("sim failed");
			$finish;
		end
	end

	// Write and finish monitor on the falling edge
	always @(negedge clk) begin
		if (write) begin
			if (!running) begin
				errors++;
				$display("Write seen outside a run at fmo_addr %0d", fmo_addr);
			end else if (exp_addr.size() == 0) begin
				errors++;
				$display("Extra write in %s at fmo_addr %0d", test_name, fmo_addr);
			end else begin
				checks++;
				if (int'(fmo_addr) != exp_addr[0]) begin
					errors++;
					$display("FAILED %s addr: expected %0d actual %0d",
						test_name, exp_addr[0], fmo_addr);
				end
				if (int'(res) != exp_val[0]) begin
					errors++;
					$display("FAILED %s res at %0d: expected %0d actual %0d",
						test_name, exp_addr[0], exp_val[0], res);
				end
				void'(exp_addr.pop_front());
				void'(exp_val.pop_front());
			end
		end
		if (finish) begin
			finish_cnt++;
			if (!running) begin
				errors++;
				$display("Finish pulse seen outside a run");
			end
			running  = 1'b0;
			run_done = 1'b1;
		end
	end

	task automatic clear_mems();
		for (int i = 0; i < FMINT_DEPTH; i++)
			fmint_mem[i] = '0;
		for (int i = 0; i < KDW_DEPTH; i++)
			kdw_mem[i] = '0;
		for (int i = 0; i < KPW_DEPTH; i++) begin
			kpw_mem[i] = '0;
			pos_mem[i] = '0;
		end
	endtask

	task automatic execute_run(input int s_v, input int fp_v, input int nof_v,
			input int tox_v, input int toy_v);
		int n_exp;
		n_exp = exp_addr.size();
		finish_cnt = 0;
		run_done   = 1'b0;
		@(posedge clk);
		S         <= s_v[0];
		first_par <= fp_v[0];
		nof       <= NOF_W'(nof_v);
		tox_n     <= TILE_W'(tox_v);
		toy_n     <= TILE_W'(toy_v);
		start     <= 1'b1;
		running = 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!run_done)
			@(posedge clk);
		// A few idle cycles to catch a second finish pulse
		repeat (3) @(posedge clk);
		if (exp_addr.size() != 0) begin
			errors++;
			$display("Run %s ended with %0d of %0d writes missing",
				test_name, exp_addr.size(), n_exp);
			exp_addr.delete();
			exp_val.delete();
		end
		if (finish_cnt != 1) begin
			errors++;
			$display("Run %s gave %0d finish pulses instead of one", test_name, finish_cnt);
		end
	endtask

	initial begin
		int fd;
		int code;
		int n;
		int a;
		int v;
		int p;
		int cfg [5];
		string tok;
		string line;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		S = 1'b0;
		first_par = 1'b0;
		nof = '0;
		tox_n = '0;
		toy_n = '0;
		fmint_data = '0;
		fmo_data = '0;
		kdw_data = '0;
		kpw_data = '0;
		kpw_pos = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		limit = 100;
		running = 1'b0;
		run_done = 1'b0;
		test_name = "reset";
		clear_mems();
		// Stale output buffer contents that a fresh run must not add in
		for (int i = 0; i < FMO_DEPTH; i++)
			fmo_mem[i] = PX_W'(1000 + 97 * i);
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);

		fd = $fopen("test/dsc_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open the golden file");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tok);
				if (code != 1)
					break;
				if (tok.substr(0, 0) == "#") begin
					code = $fgets(line, fd);
				end else if (tok == "run") begin
					code = $fscanf(fd, "%s %d %d %d %d %d", test_name,
						cfg[0], cfg[1], cfg[2], cfg[3], cfg[4]);
					clear_mems();
					limit = limit + 2 * ((WIN_N + 1) + cfg[3] * cfg[4] *
						(WIN_N + 2 + cfg[2] * (NNP + 3)));
				end else begin
					code = $fscanf(fd, "%d", n);
					for (int i = 0; i < n; i++) begin
						if (tok == "kpw") begin
							code = $fscanf(fd, "%d %d %d", a, v, p);
							kpw_mem[a] = WG_W'(v);
							pos_mem[a] = POS_W'(p);
						end else begin
							code = $fscanf(fd, "%d %d", a, v);
							if (tok == "kdw")
								kdw_mem[a] = WG_W'(v);
							else if (tok == "fmint")
								fmint_mem[a] = PX_W'(v);
							else begin
								exp_addr.push_back(a);
								exp_val.push_back(v);
							end
						end
					end
					if (tok == "exp")
						execute_run(cfg[0], cfg[1], cfg[2], cfg[3], cfg[4]);
				end
			end
			$fclose(fd);
		end
		if (checks == 0) begin
			errors++;
			$display("No writes were checked");
		end
		$display("Errors: %0d, writes checked: %0d", errors, checks);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
